// ==== hw/axi_lite_pkg.sv ====
package axi_lite_pkg;

    // Width of the AXI-Lite data bus in bits
    localparam int DATA_W = 32;

    // One write strobe bit for each byte lane of the data bus
    localparam int STRB_W = DATA_W / 8;

    // Width of the BRESP and RRESP fields
    localparam int RESP_W = 2;

    // Normal completion of a read or write
    localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

    // Responder error, returned for addresses beyond the end of the memory
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== hw/axi_lite_if.sv ====
`timescale 1ns/1ps

// AXI-Lite bus with the five channels and no clock or reset members
interface axi_lite_if
    import axi_lite_pkg::*;
#(
    parameter int ADDR_W = 12
);

    // Write address channel
    logic              awvalid;
    logic              awready;
    logic [ADDR_W-1:0] awaddr;

    // Write data channel
    logic              wvalid;
    logic              wready;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;

    // Write response channel
    logic              bvalid;
    logic              bready;
    logic [RESP_W-1:0] bresp;

    // Read address channel
    logic              arvalid;
    logic              arready;
    logic [ADDR_W-1:0] araddr;

    // Read data channel
    logic              rvalid;
    logic              rready;
    logic [DATA_W-1:0] rdata;
    logic [RESP_W-1:0] rresp;

    // The side that issues requests and takes responses
    modport requester
    (
        output awvalid, awaddr, wvalid, wdata, wstrb, arvalid, araddr, bready, rready,
        input  awready, wready, arready, bvalid, bresp, rvalid, rdata, rresp
    );

    // The side that serves requests and returns responses
    modport responder
    (
        input  awvalid, awaddr, wvalid, wdata, wstrb, arvalid, araddr, bready, rready,
        output awready, wready, arready, bvalid, bresp, rvalid, rdata, rresp
    );

endinterface

// ==== hw/ready_enable_skid.sv ====
`timescale 1ns/1ps

// A single pipeline stage for one valid/ready channel
// The main register feeds the destination and the skid register catches the
// one payload that may arrive while ready toward the source is still high
module ready_enable_skid
#(
    parameter int N_DATA_BITS = 32
)
(
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   enable_from_src,
    input  logic [N_DATA_BITS-1:0] data_from_src,
    output logic                   ready_to_src,

    output logic                   enable_to_dst,
    output logic [N_DATA_BITS-1:0] data_to_dst,
    input  logic                   ready_from_dst
);

    logic                   main_valid;
    logic [N_DATA_BITS-1:0] main_data;
    logic                   skid_valid;
    logic [N_DATA_BITS-1:0] skid_data;
    logic                   ready_q;
    logic                   src_take;
    logic                   main_free;

    // A transfer from the source happens only while the registered ready is high
    assign src_take = enable_from_src && ready_q;

    // The main entry can be loaded when it is empty or is being drained this cycle
    assign main_free = !main_valid || ready_from_dst;

    assign ready_to_src  = ready_q;
    assign enable_to_dst = main_valid;
    assign data_to_dst   = main_data;

    // Occupancy of the two entries and the registered ready
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            ready_q    <= 1'b1;
        end
        else if (main_free)
        begin
            // The skid entry, when full, moves ahead of anything new
            // Ready is low in that case, so no source transfer competes with it
            main_valid <= skid_valid || src_take;
            skid_valid <= 1'b0;
            ready_q    <= 1'b1;
        end
        else if (src_take)
        begin
            // Main is stalled, so the in-flight payload lands in the skid entry
            skid_valid <= 1'b1;
            ready_q    <= 1'b0;
        end
    end

    // Payload registers follow the same moves as the valid bits
    always_ff @(posedge clk)
    begin
        if (main_free)
        begin
            main_data <= skid_valid ? skid_data : data_from_src;
        end
        if (!main_free && src_take)
        begin
            skid_data <= data_from_src;
        end
    end

    // A payload offered to the destination must not change until it is taken
    a_dst_stable : assert property (@(posedge clk) disable iff (!rst_n)
        enable_to_dst && !ready_from_dst |=> enable_to_dst && $stable(data_to_dst));

endmodule

// ==== hw/axi_lite_if_reg.sv ====
`timescale 1ns/1ps

// Register slice between two AXI-Lite buses
// Every channel gets N_REG_STAGES skid stages in its own direction
module axi_lite_if_reg
    import axi_lite_pkg::*;
#(
    parameter int N_REG_STAGES = 2,
    parameter int ADDR_W       = 12
)
(
    input  logic          clk,
    input  logic          rst_n,
    axi_lite_if.responder up,
    axi_lite_if.requester down
);

    // Entry 0 is the upstream side and the last entry is the downstream side
    // With no stages the single entry joins both sides by wires alone
    axi_lite_if #(.ADDR_W(ADDR_W)) pipe [0:N_REG_STAGES] ();

    // Requests enter the chain from upstream and responses leave it there
    assign pipe[0].awvalid = up.awvalid;
    assign pipe[0].awaddr  = up.awaddr;
    assign pipe[0].wvalid  = up.wvalid;
    assign pipe[0].wdata   = up.wdata;
    assign pipe[0].wstrb   = up.wstrb;
    assign pipe[0].arvalid = up.arvalid;
    assign pipe[0].araddr  = up.araddr;
    assign pipe[0].bready  = up.bready;
    assign pipe[0].rready  = up.rready;
    assign up.awready      = pipe[0].awready;
    assign up.wready       = pipe[0].wready;
    assign up.arready      = pipe[0].arready;
    assign up.bvalid       = pipe[0].bvalid;
    assign up.bresp        = pipe[0].bresp;
    assign up.rvalid       = pipe[0].rvalid;
    assign up.rdata        = pipe[0].rdata;
    assign up.rresp        = pipe[0].rresp;

    // Requests leave the chain downstream and responses enter it there
    assign down.awvalid                 = pipe[N_REG_STAGES].awvalid;
    assign down.awaddr                  = pipe[N_REG_STAGES].awaddr;
    assign down.wvalid                  = pipe[N_REG_STAGES].wvalid;
    assign down.wdata                   = pipe[N_REG_STAGES].wdata;
    assign down.wstrb                   = pipe[N_REG_STAGES].wstrb;
    assign down.arvalid                 = pipe[N_REG_STAGES].arvalid;
    assign down.araddr                  = pipe[N_REG_STAGES].araddr;
    assign down.bready                  = pipe[N_REG_STAGES].bready;
    assign down.rready                  = pipe[N_REG_STAGES].rready;
    assign pipe[N_REG_STAGES].awready   = down.awready;
    assign pipe[N_REG_STAGES].wready    = down.wready;
    assign pipe[N_REG_STAGES].arready   = down.arready;
    assign pipe[N_REG_STAGES].bvalid    = down.bvalid;
    assign pipe[N_REG_STAGES].bresp     = down.bresp;
    assign pipe[N_REG_STAGES].rvalid    = down.rvalid;
    assign pipe[N_REG_STAGES].rdata     = down.rdata;
    assign pipe[N_REG_STAGES].rresp     = down.rresp;

    genvar s;
    for (s = 1; s <= N_REG_STAGES; s++)
    begin : stage
        // W and R carry two fields, so they are packed into one vector per skid
        logic [DATA_W+STRB_W-1:0] w_out;
        logic [DATA_W+RESP_W-1:0] r_out;

        assign {pipe[s].wdata, pipe[s].wstrb}   = w_out;
        assign {pipe[s-1].rdata, pipe[s-1].rresp} = r_out;

        // AW, W and AR run from entry s-1 toward entry s
        ready_enable_skid #(.N_DATA_BITS(ADDR_W)) aw_skid
        (
            .clk(clk),
            .rst_n(rst_n),
            .enable_from_src(pipe[s-1].awvalid),
            .data_from_src(pipe[s-1].awaddr),
            .ready_to_src(pipe[s-1].awready),
            .enable_to_dst(pipe[s].awvalid),
            .data_to_dst(pipe[s].awaddr),
            .ready_from_dst(pipe[s].awready)
        );

        ready_enable_skid #(.N_DATA_BITS(DATA_W + STRB_W)) w_skid
        (
            .clk(clk),
            .rst_n(rst_n),
            .enable_from_src(pipe[s-1].wvalid),
            .data_from_src({pipe[s-1].wdata, pipe[s-1].wstrb}),
            .ready_to_src(pipe[s-1].wready),
            .enable_to_dst(pipe[s].wvalid),
            .data_to_dst(w_out),
            .ready_from_dst(pipe[s].wready)
        );

        ready_enable_skid #(.N_DATA_BITS(ADDR_W)) ar_skid
        (
            .clk(clk),
            .rst_n(rst_n),
            .enable_from_src(pipe[s-1].arvalid),
            .data_from_src(pipe[s-1].araddr),
            .ready_to_src(pipe[s-1].arready),
            .enable_to_dst(pipe[s].arvalid),
            .data_to_dst(pipe[s].araddr),
            .ready_from_dst(pipe[s].arready)
        );

        // B and R run back from entry s toward entry s-1
        ready_enable_skid #(.N_DATA_BITS(RESP_W)) b_skid
        (
            .clk(clk),
            .rst_n(rst_n),
            .enable_from_src(pipe[s].bvalid),
            .data_from_src(pipe[s].bresp),
            .ready_to_src(pipe[s].bready),
            .enable_to_dst(pipe[s-1].bvalid),
            .data_to_dst(pipe[s-1].bresp),
            .ready_from_dst(pipe[s-1].bready)
        );

        ready_enable_skid #(.N_DATA_BITS(DATA_W + RESP_W)) r_skid
        (
            .clk(clk),
            .rst_n(rst_n),
            .enable_from_src(pipe[s].rvalid),
            .data_from_src({pipe[s].rdata, pipe[s].rresp}),
            .ready_to_src(pipe[s].rready),
            .enable_to_dst(pipe[s-1].rvalid),
            .data_to_dst(r_out),
            .ready_from_dst(pipe[s-1].rready)
        );
    end

endmodule

// ==== hw/axi_lite_mem_array.sv ====
`timescale 1ns/1ps

// Word storage with one byte-strobed write port and one registered read port
module axi_lite_mem_array
    import axi_lite_pkg::*;
#(
    parameter int DEPTH = 256
)
(
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_idx,
    input  logic [DATA_W-1:0]        wr_data,
    input  logic [STRB_W-1:0]        wr_strb,
    input  logic                     rd_en,
    input  logic [$clog2(DEPTH)-1:0] rd_idx,
    output logic [DATA_W-1:0]        rd_data
);

    logic [DATA_W-1:0] mem [0:DEPTH-1];

    always_ff @(posedge clk)
    begin
        // Each strobe bit enables its own byte lane
        if (wr_en)
        begin
            for (int i = 0; i < STRB_W; i++)
            begin
                if (wr_strb[i])
                begin
                    mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end

        // The read register holds its word until the next read
        // A write to the same word on this edge is not yet visible here
        if (rd_en)
        begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

// ==== hw/axi_lite_mem_ctrl.sv ====
`timescale 1ns/1ps

// AXI-Lite responder in front of the word array
// One write and one read may be outstanding, each held in its response register
module axi_lite_mem_ctrl
    import axi_lite_pkg::*;
#(
    parameter int ADDR_W = 12,
    parameter int DEPTH  = 256
)
(
    input  logic                     clk,
    input  logic                     rst_n,
    axi_lite_if.responder            bus,

    output logic                     wr_en,
    output logic [$clog2(DEPTH)-1:0] wr_idx,
    output logic [DATA_W-1:0]        wr_data,
    output logic [STRB_W-1:0]        wr_strb,
    output logic                     rd_en,
    output logic [$clog2(DEPTH)-1:0] rd_idx,
    input  logic [DATA_W-1:0]        rd_data
);

    localparam int IDX_W = $clog2(DEPTH);

    logic              ctrl_rdy;
    logic              bvalid_q;
    logic [RESP_W-1:0] bresp_q;
    logic              rvalid_q;
    logic              rd_err_q;
    logic [ADDR_W-3:0] aw_word;
    logic [ADDR_W-3:0] ar_word;
    logic              aw_ok;
    logic              ar_ok;
    logic              wr_take;
    logic              rd_take;

    // Byte addresses become word indexes; the two low bits select a byte and are dropped
    assign aw_word = bus.awaddr[ADDR_W-1:2];
    assign ar_word = bus.araddr[ADDR_W-1:2];

    // Anything at or past DEPTH words gets SLVERR
    assign aw_ok = (aw_word < DEPTH);
    assign ar_ok = (ar_word < DEPTH);

    // AW and W are taken together, and only when no write response is waiting
    assign wr_take     = ctrl_rdy && bus.awvalid && bus.wvalid && !bvalid_q;
    assign bus.awready = wr_take;
    assign bus.wready  = wr_take;

    // AR is open whenever the read response register is empty
    assign bus.arready = ctrl_rdy && !rvalid_q;
    assign rd_take     = bus.arvalid && bus.arready;

    // The array is written on the accepting edge unless the address is out of range
    assign wr_en   = wr_take && aw_ok;
    assign wr_idx  = aw_word[IDX_W-1:0];
    assign wr_data = bus.wdata;
    assign wr_strb = bus.wstrb;

    // Out-of-range reads leave the array read register alone
    assign rd_en  = rd_take && ar_ok;
    assign rd_idx = ar_word[IDX_W-1:0];

    assign bus.bvalid = bvalid_q;
    assign bus.bresp  = bresp_q;
    assign bus.rvalid = rvalid_q;
    assign bus.rresp  = rd_err_q ? RESP_SLVERR : RESP_OKAY;
    // An erroring read returns zero in place of the array word
    assign bus.rdata  = rd_err_q ? '0 : rd_data;

    // Response valids and the one-cycle start-up hold on the ready lines
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ctrl_rdy <= 1'b0;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end
        else
        begin
            ctrl_rdy <= 1'b1;
            if (wr_take)
            begin
                bvalid_q <= 1'b1;
            end
            else if (bus.bready)
            begin
                bvalid_q <= 1'b0;
            end
            if (rd_take)
            begin
                rvalid_q <= 1'b1;
            end
            else if (bus.rready)
            begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Response payloads are captured with the request and held until taken
    always_ff @(posedge clk)
    begin
        if (wr_take)
        begin
            bresp_q <= aw_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_take)
        begin
            rd_err_q <= !ar_ok;
        end
    end

    // A write response may not change or vanish before bready takes it
    a_b_hold : assert property (@(posedge clk) disable iff (!rst_n)
        bus.bvalid && !bus.bready |=> bus.bvalid && $stable(bus.bresp));

    // The read data comes from the array register, so this covers both modules
    a_r_hold : assert property (@(posedge clk) disable iff (!rst_n)
        bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata) && $stable(bus.rresp));

endmodule

// ==== hw/axi_lite_mem_sys.sv ====
`timescale 1ns/1ps

// AXI-Lite memory subsystem
// Requests pass through the register slice to the controller and its word array
module axi_lite_mem_sys
    import axi_lite_pkg::*;
#(
    parameter int ADDR_W       = 12,
    parameter int DEPTH        = 256,
    parameter int N_REG_STAGES = 2
)
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic              awvalid,
    output logic              awready,
    input  logic [ADDR_W-1:0] awaddr,

    input  logic              wvalid,
    output logic              wready,
    input  logic [DATA_W-1:0] wdata,
    input  logic [STRB_W-1:0] wstrb,

    output logic              bvalid,
    input  logic              bready,
    output logic [RESP_W-1:0] bresp,

    input  logic              arvalid,
    output logic              arready,
    input  logic [ADDR_W-1:0] araddr,

    output logic              rvalid,
    input  logic              rready,
    output logic [DATA_W-1:0] rdata,
    output logic [RESP_W-1:0] rresp
);

    localparam int IDX_W = $clog2(DEPTH);

    // Bus from the top ports into the slice, and bus from the slice to the controller
    axi_lite_if #(.ADDR_W(ADDR_W)) up_if ();
    axi_lite_if #(.ADDR_W(ADDR_W)) dn_if ();

    // Array port wires
    logic             wr_en;
    logic [IDX_W-1:0] wr_idx;
    logic [DATA_W-1:0] wr_data;
    logic [STRB_W-1:0] wr_strb;
    logic             rd_en;
    logic [IDX_W-1:0] rd_idx;
    logic [DATA_W-1:0] rd_data;

    // The top ports act as the requester on the upstream bus
    assign up_if.awvalid = awvalid;
    assign up_if.awaddr  = awaddr;
    assign up_if.wvalid  = wvalid;
    assign up_if.wdata   = wdata;
    assign up_if.wstrb   = wstrb;
    assign up_if.bready  = bready;
    assign up_if.arvalid = arvalid;
    assign up_if.araddr  = araddr;
    assign up_if.rready  = rready;
    assign awready       = up_if.awready;
    assign wready        = up_if.wready;
    assign bvalid        = up_if.bvalid;
    assign bresp         = up_if.bresp;
    assign arready       = up_if.arready;
    assign rvalid        = up_if.rvalid;
    assign rdata         = up_if.rdata;
    assign rresp         = up_if.rresp;

    axi_lite_if_reg #(.N_REG_STAGES(N_REG_STAGES), .ADDR_W(ADDR_W)) slice
    (
        .clk(clk),
        .rst_n(rst_n),
        .up(up_if),
        .down(dn_if)
    );

    axi_lite_mem_ctrl #(.ADDR_W(ADDR_W), .DEPTH(DEPTH)) ctrl
    (
        .clk(clk),
        .rst_n(rst_n),
        .bus(dn_if),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_data(wr_data),
        .wr_strb(wr_strb),
        .rd_en(rd_en),
        .rd_idx(rd_idx),
        .rd_data(rd_data)
    );

    axi_lite_mem_array #(.DEPTH(DEPTH)) mem
    (
        .clk(clk),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_data(wr_data),
        .wr_strb(wr_strb),
        .rd_en(rd_en),
        .rd_idx(rd_idx),
        .rd_data(rd_data)
    );

endmodule

// ==== sim/tb_axi_lite_mem_sys.sv ====
`timescale 1ns/1ps

// Testbench for the AXI-Lite memory subsystem
// One process drives requests and response back-pressure, another checks responses
module tb_axi_lite_mem_sys
    import axi_lite_pkg::*;
();

    localparam int ADDR_W       = 12;
    localparam int DEPTH        = 256;
    localparam int N_REG_STAGES = 2;
    localparam int WORD_W       = ADDR_W - 2;
    localparam int IDX_W        = $clog2(DEPTH);

    // Address choices for a phase
    localparam int MODE_FILL = 0;
    localparam int MODE_IN   = 1;
    localparam int MODE_OUT  = 2;
    localparam int MODE_ANY  = 3;

    // Longest stretch that bready or rready is held low
    localparam int MAX_STALL = 8;
    // Sum of all writes and reads issued by the phases below
    localparam int N_TRANS   = 1960;
    localparam int MARGIN    = 2000;
    localparam int TIMEOUT   = N_TRANS * (2 * N_REG_STAGES + 1 + MAX_STALL) + MARGIN;

    logic              clk;
    logic              rst_n;
    logic              awvalid;
    logic              awready;
    logic [ADDR_W-1:0] awaddr;
    logic              wvalid;
    logic              wready;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              bvalid;
    logic              bready;
    logic [RESP_W-1:0] bresp;
    logic              arvalid;
    logic              arready;
    logic [ADDR_W-1:0] araddr;
    logic              rvalid;
    logic              rready;
    logic [DATA_W-1:0] rdata;
    logic [RESP_W-1:0] rresp;

    logic [31:0]              lfsr_state;
    logic [DATA_W-1:0]        model_mem [0:DEPTH-1];
    logic [RESP_W-1:0]        exp_b [$];
    logic [RESP_W+DATA_W-1:0] exp_r [$];
    int                       b_hold;
    int                       r_hold;
    int                       cycles;

    axi_lite_mem_sys dut
    (
        .clk(clk),
        .rst_n(rst_n),
        .awvalid(awvalid),
        .awready(awready),
        .awaddr(awaddr),
        .wvalid(wvalid),
        .wready(wready),
        .wdata(wdata),
        .wstrb(wstrb),
        .bvalid(bvalid),
        .bready(bready),
        .bresp(bresp),
        .arvalid(arvalid),
        .arready(arready),
        .araddr(araddr),
        .rvalid(rvalid),
        .rready(rready),
        .rdata(rdata),
        .rresp(rresp)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Right-shifting Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Takes n bits from the generator, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Fill value that mixes every bit of the word index
    function automatic logic [DATA_W-1:0] fill_word(input int idx);
        return DATA_W'(32'h9e37_79b9 * (idx + 1));
    endfunction

    // Expected response and data of one access, and the model memory update
    // The result is {resp, data}; data only matters for reads
    function automatic logic [RESP_W+DATA_W-1:0] ref_access(input logic is_wr,
        input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
        input logic [STRB_W-1:0] strb);
        int word;
        word = int'(addr >> 2);
        if (word >= DEPTH)
        begin
            // Past the end nothing is stored and the read data is zero
            return {RESP_SLVERR, {DATA_W{1'b0}}};
        end
        if (is_wr)
        begin
            for (int b = 0; b < STRB_W; b++)
            begin
                if (strb[b])
                begin
                    model_mem[word][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
        return {RESP_OKAY, model_mem[word]};
    endfunction

    // Word index for the n-th access of a phase
    function automatic logic [WORD_W-1:0] pick_word(input int mode, input int n);
        logic [31:0] rnd;
        int          w;
        rnd = '0;
        if (mode == MODE_ANY)
        begin
            // About one access in four goes out of range
            rnd = rand_bits(2);
        end
        if (mode == MODE_FILL)
        begin
            w = n;
        end
        else if (mode == MODE_OUT || (mode == MODE_ANY && rnd == 0))
        begin
            rnd = rand_bits(WORD_W);
            w = DEPTH + int'(rnd) % (2 ** WORD_W - DEPTH);
        end
        else
        begin
            rnd = rand_bits(IDX_W);
            w = int'(rnd) % DEPTH;
        end
        return WORD_W'(w);
    endfunction

    // Response ready for the next cycle, with random low stretches when stall is set
    function automatic logic next_ready(inout int hold, input bit stall);
        logic [31:0] rnd;
        if (hold > 0)
        begin
            hold--;
            return 1'b0;
        end
        if (stall)
        begin
            rnd = rand_bits(2);
            if (rnd == 0)
            begin
                rnd = rand_bits(3);
                hold = int'(rnd);
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped on the first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
        input logic [63:0] exp);
        if (got !== exp)
        begin
            abort_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Runs n_wr writes and n_rd reads, one outstanding per channel, until all responses arrive
    // A read never targets the word of a write in flight, and the other way round,
    // so the model can be updated when a request is issued
    task automatic run_phase(input int n_wr, input int n_rd, input int mode,
        input bit rand_strb, input bit pace, input bit stall);
        int                       wr_issued;
        int                       rd_issued;
        int                       wr_done;
        int                       rd_done;
        bit                       wr_busy;
        bit                       rd_busy;
        bit                       aw_todo;
        bit                       w_todo;
        bit                       ar_todo;
        logic [WORD_W-1:0]        wr_word;
        logic [WORD_W-1:0]        rd_word;
        logic [ADDR_W-1:0]        wr_addr;
        logic [ADDR_W-1:0]        rd_addr;
        logic [DATA_W-1:0]        wr_data;
        logic [STRB_W-1:0]        wr_strb;
        logic [31:0]              rnd;
        logic [RESP_W+DATA_W-1:0] res;
        wr_issued = 0;
        rd_issued = 0;
        wr_done   = 0;
        rd_done   = 0;
        wr_busy   = 1'b0;
        rd_busy   = 1'b0;
        aw_todo   = 1'b0;
        w_todo    = 1'b0;
        ar_todo   = 1'b0;
        wr_word   = '0;
        rd_word   = '0;
        while (wr_done < n_wr || rd_done < n_rd)
        begin
            @(posedge clk);
            // Handshakes completed on this edge
            if (awvalid && awready)
            begin
                awvalid <= 1'b0;
            end
            if (wvalid && wready)
            begin
                wvalid <= 1'b0;
            end
            if (arvalid && arready)
            begin
                arvalid <= 1'b0;
            end
            if (bvalid && bready)
            begin
                wr_busy = 1'b0;
                wr_done++;
            end
            if (rvalid && rready)
            begin
                rd_busy = 1'b0;
                rd_done++;
            end
            bready <= next_ready(b_hold, stall);
            rready <= next_ready(r_hold, stall);

            if (!wr_busy && wr_issued < n_wr)
            begin
                wr_word = pick_word(mode, wr_issued);
                if (rd_busy && wr_word == rd_word)
                begin
                    wr_word[0] = ~wr_word[0];
                end
                // The two byte-select bits are random and must be ignored
                rnd     = rand_bits(2);
                wr_addr = {wr_word, rnd[1:0]};
                wr_data = (mode == MODE_FILL) ? fill_word(wr_issued) : rand_bits(DATA_W);
                rnd     = rand_bits(STRB_W);
                wr_strb = rand_strb ? rnd[STRB_W-1:0] : {STRB_W{1'b1}};
                res     = ref_access(1'b1, wr_addr, wr_data, wr_strb);
                exp_b.push_back(res[DATA_W +: RESP_W]);
                wr_busy = 1'b1;
                aw_todo = 1'b1;
                w_todo  = 1'b1;
                wr_issued++;
            end
            if (!rd_busy && rd_issued < n_rd)
            begin
                rd_word = pick_word(mode, rd_issued);
                if (wr_busy && rd_word == wr_word)
                begin
                    rd_word[0] = ~rd_word[0];
                end
                rnd     = rand_bits(2);
                rd_addr = {rd_word, rnd[1:0]};
                res     = ref_access(1'b0, rd_addr, '0, '0);
                exp_r.push_back(res);
                rd_busy = 1'b1;
                ar_todo = 1'b1;
                rd_issued++;
            end

            // With pace set each valid rises on a later random cycle
            if (aw_todo && (!pace || rand_bits(1) != 0))
            begin
                awvalid <= 1'b1;
                awaddr  <= wr_addr;
                aw_todo = 1'b0;
            end
            if (w_todo && (!pace || rand_bits(1) != 0))
            begin
                wvalid <= 1'b1;
                wdata  <= wr_data;
                wstrb  <= wr_strb;
                w_todo = 1'b0;
            end
            if (ar_todo && (!pace || rand_bits(1) != 0))
            begin
                arvalid <= 1'b1;
                araddr  <= rd_addr;
                ar_todo = 1'b0;
            end
        end
    endtask

    // Every response handshake is matched against the oldest expected entry of its channel
    always @(posedge clk)
    begin
        logic [RESP_W-1:0]        eb;
        logic [RESP_W+DATA_W-1:0] er;
        if (rst_n)
        begin
            if (bvalid && bready)
            begin
                if (exp_b.size() == 0)
                begin
                    abort_run("A write response arrived with no write outstanding");
                end
                eb = exp_b.pop_front();
                check_value("bresp", 64'(bresp), 64'(eb));
            end
            if (rvalid && rready)
            begin
                if (exp_r.size() == 0)
                begin
                    abort_run("A read response arrived with no read outstanding");
                end
                er = exp_r.pop_front();
                check_value("rresp", 64'(rresp), 64'(er[DATA_W +: RESP_W]));
                check_value("rdata", 64'(rdata), 64'(er[DATA_W-1:0]));
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT)
        begin
            abort_run($sformatf("Timeout: the tests did not finish within %0d cycles", TIMEOUT));
        end
    end

    initial
    begin
        lfsr_state = 32'h22e6bf4e;
        cycles     = 0;
        b_hold     = 0;
        r_hold     = 0;
        rst_n      = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        bready     = 1'b0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("bvalid", 64'(bvalid), 64'(0));
        check_value("rvalid", 64'(rvalid), 64'(0));
        // Skid stages come out of reset empty and ready, so the request channels are open
        check_value("awready", 64'(awready), 64'(N_REG_STAGES > 0));
        check_value("wready", 64'(wready), 64'(N_REG_STAGES > 0));
        check_value("arready", 64'(arready), 64'(N_REG_STAGES > 0));

        // Full-strobe fill of every word, then a read-back of all of them
        run_phase(DEPTH, 0, MODE_FILL, 1'b0, 1'b0, 1'b0);
        run_phase(0, DEPTH, MODE_FILL, 1'b0, 1'b0, 1'b0);
        // Partial strobes merge into the stored words
        run_phase(64, 64, MODE_IN, 1'b1, 1'b0, 1'b0);
        // Out-of-range accesses, then a read-back shows nothing was disturbed
        run_phase(32, 32, MODE_OUT, 1'b1, 1'b0, 1'b0);
        run_phase(0, DEPTH, MODE_FILL, 1'b0, 1'b0, 1'b0);
        // Response back-pressure
        run_phase(100, 100, MODE_IN, 1'b1, 1'b0, 1'b1);
        // Long mix over the whole address space with random valid timing
        run_phase(400, 400, MODE_ANY, 1'b1, 1'b1, 1'b1);

        // The checker handles the last handshake on the same edge
        @(posedge clk);
        if (exp_b.size() != 0 || exp_r.size() != 0)
        begin
            abort_run("Some responses never arrived");
        end
        else
        begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// ==== flist.f ====
hw/axi_lite_pkg.sv
hw/axi_lite_if.sv
hw/ready_enable_skid.sv
hw/axi_lite_if_reg.sv
hw/axi_lite_mem_array.sv
hw/axi_lite_mem_ctrl.sv
hw/axi_lite_mem_sys.sv
sim/tb_axi_lite_mem_sys.sv

// ==== Makefile ====
SIM   := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := tb_axi_lite_mem_sys
FLIST := flist.f
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
